// ==== nts_api_decode.sv ====
// API block decode and engine ID words
`timescale 1ns/10ps
`default_nettype none

module nts_api_decode (
  input  wire                               i_api_cs,
  input  wire                               i_api_we,
  input  wire  [nts_pkg::API_ADDR_W-1:0]    i_api_address,
  input  wire  [nts_pkg::API_DATA_W-1:0]    i_api_write_data,  // No writable register
  output logic [nts_pkg::API_DATA_W-1:0]    o_api_read_data,
  output logic [nts_pkg::API_OFFSET_W-1:0]  o_offset,
  output logic                              o_read_debug,
  input  wire  [nts_pkg::API_DATA_W-1:0]    i_debug_read_data
);

  import nts_pkg::*;

  api_addr_t addr;
  logic      api_read;
  logic      read_engine;

  //------------------------------------------------------------
  // Address split and block selects
  //------------------------------------------------------------

  assign addr.raw = i_api_address;
  assign o_offset = addr.field.offset;

  assign api_read     = i_api_cs && !i_api_we;  // Writes fall through
  assign o_read_debug = api_read && (addr.field.block == BLOCK_DEBUG);
  assign read_engine  = api_read && (addr.field.block == BLOCK_ENGINE);

  //------------------------------------------------------------
  // Read mux
  //------------------------------------------------------------

  // Engine words are matched on the full address word, so the
  // block number is part of every case item
  always_comb
  begin : read_mux
    o_api_read_data = '0;
    if (o_read_debug)
    begin
      o_api_read_data = i_debug_read_data;
    end
    else if (read_engine)
    begin
      case (addr.raw)
        {BLOCK_ENGINE, ADDR_NAME0}:   o_api_read_data = CORE_NAME0;
        {BLOCK_ENGINE, ADDR_NAME1}:   o_api_read_data = CORE_NAME1;
        {BLOCK_ENGINE, ADDR_VERSION}: o_api_read_data = CORE_VERSION;
        {BLOCK_ENGINE, ADDR_CTRL}:    o_api_read_data = CTRL_VALUE;
        default: ;                    // Unmapped engine offset
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== nts_debug_regs.sv ====
// Debug block register readout
`timescale 1ns/10ps
`default_nettype none

module nts_debug_regs (
  input  wire                                                 i_read,     // Qualified debug read
  input  wire  [nts_pkg::API_OFFSET_W-1:0]                    i_offset,
  input  wire  [nts_pkg::NUM_CNT-1:0][nts_pkg::CNT_W-1:0]      i_count,
  input  wire  [nts_pkg::NUM_CNT-1:0][nts_pkg::API_DATA_W-1:0] i_lsb,
  input  wire  [nts_pkg::API_DATA_W-1:0]                      i_systick,
  output logic [nts_pkg::API_DATA_W-1:0]                      o_read_data,
  output logic [nts_pkg::NUM_CNT-1:0]                         o_load
);

  import nts_pkg::*;

  logic [NUM_CNT-1:0] hit_msb;  // Offset names a counter's upper word
  logic [NUM_CNT-1:0] hit_lsb;  // Offset names a counter's lower word

  //------------------------------------------------------------
  // Counter address match
  //------------------------------------------------------------

  for (genvar g = 0; g < NUM_CNT; g++)
  begin : g_match
    assign hit_msb[g] = (i_offset == CNT_ADDR[g]);
    assign hit_lsb[g] = (i_offset == CNT_ADDR[g] + API_OFFSET_W'(1));
  end

  // Snapshot strobe only on a real read of the upper word
  assign o_load = i_read ? hit_msb : '0;

  //------------------------------------------------------------
  // Read data mux
  //------------------------------------------------------------

  always_comb
  begin : read_mux
    o_read_data = '0;
    if (i_read)
    begin
      case (i_offset)
        ADDR_DEBUG_NAME:      o_read_data = DEBUG_NAME;
        ADDR_DEBUG_SYSTICK32: o_read_data = i_systick;
        default: ;
      endcase

      // Counter offsets never overlap the name or tick offsets
      for (int i = 0; i < NUM_CNT; i++)
      begin
        if (hit_msb[i])
        begin
          o_read_data = i_count[i][CNT_W-1:API_DATA_W];
        end
        if (hit_lsb[i])
        begin
          o_read_data = i_lsb[i];  // Held since the last upper read
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== nts_engine_stats.sv ====
// NTS engine statistics top level
`timescale 1ns/10ps
`default_nettype none

module nts_engine_stats (
  input  wire                             i_clk,
  input  wire                             i_areset,
  input  wire                             i_api_cs,
  input  wire                             i_api_we,
  input  wire [nts_pkg::API_ADDR_W-1:0]   i_api_address,
  input  wire [nts_pkg::API_DATA_W-1:0]   i_api_write_data,
  output wire [nts_pkg::API_DATA_W-1:0]   o_api_read_data,
  input  wire [nts_pkg::NUM_CNT-1:0]      i_evt   // Bit order follows counter index
);

  import nts_pkg::*;

  //------------------------------------------------------------
  // Internal wires
  //------------------------------------------------------------

  wire [API_OFFSET_W-1:0]            api_offset;
  wire                               read_debug;
  wire [API_DATA_W-1:0]              debug_read_data;
  wire [NUM_CNT-1:0][CNT_W-1:0]      count;
  wire [API_DATA_W-1:0]              systick;
  wire [NUM_CNT-1:0][API_DATA_W-1:0] lsb;
  wire [NUM_CNT-1:0]                 lsb_load;

  //------------------------------------------------------------
  // API decode
  //------------------------------------------------------------

  nts_api_decode u_api_decode (
    .i_api_cs          (i_api_cs),
    .i_api_we          (i_api_we),
    .i_api_address     (i_api_address),
    .i_api_write_data  (i_api_write_data),
    .o_api_read_data   (o_api_read_data),
    .o_offset          (api_offset),
    .o_read_debug      (read_debug),
    .i_debug_read_data (debug_read_data)
  );

  //------------------------------------------------------------
  // Counters, snapshots and debug readout
  //------------------------------------------------------------

  nts_stat_counters u_counters (
    .i_clk     (i_clk),
    .i_areset  (i_areset),
    .i_evt     (i_evt),
    .o_count   (count),
    .o_systick (systick)
  );

  nts_lsb_snapshot u_snapshot (
    .i_clk    (i_clk),
    .i_areset (i_areset),
    .i_load   (lsb_load),
    .i_count  (count),
    .o_lsb    (lsb)
  );

  nts_debug_regs u_debug (
    .i_read      (read_debug),
    .i_offset    (api_offset),
    .i_count     (count),
    .i_lsb       (lsb),
    .i_systick   (systick),
    .o_read_data (debug_read_data),
    .o_load      (lsb_load)
  );

endmodule

`default_nettype wire

// ==== nts_engine_stats_sva.sv ====
// Statistics API assertions
`timescale 1ns/10ps
`default_nettype none

module nts_engine_stats_sva (
  input wire        i_clk,
  input wire        i_areset,
  input wire        i_api_cs,
  input wire        i_api_we,
  input wire [31:0] i_api_read_data,
  input wire [5:0]  i_load,
  input wire [31:0] i_systick
);

  int fail_count = 0;  // Failed assertion count

  // Idle bus reads back zero
  a_idle_zero : assert property (
    @(posedge i_clk) disable iff (i_areset)
    !i_api_cs |-> (i_api_read_data == 32'h0)
  )
  else
  begin
    fail_count++;
    $error("read data is not zero while chip select is low");
  end

  a_no_load_on_write : assert property (
    @(posedge i_clk) disable iff (i_areset)
    (i_api_cs && i_api_we) |-> (i_load == 6'h0)
  )
  else
  begin
    fail_count++;
    $error("snapshot strobe fired during a write");
  end

  // First edge after release still holds the reset value
  a_tick_step : assert property (
    @(posedge i_clk) disable iff (i_areset)
    !$past(i_areset) |-> (i_systick == $past(i_systick) + 32'd1)
  )
  else
  begin
    fail_count++;
    $error("system tick did not advance by one");
  end

endmodule

`default_nettype wire

// ==== nts_lsb_snapshot.sv ====
// Counter lower-word snapshots
`timescale 1ns/10ps
`default_nettype none

module nts_lsb_snapshot (
  input  wire                                                 i_clk,
  input  wire                                                 i_areset,
  input  wire  [nts_pkg::NUM_CNT-1:0]                         i_load,  // Upper-word read strobes
  input  wire  [nts_pkg::NUM_CNT-1:0][nts_pkg::CNT_W-1:0]      i_count,
  output logic [nts_pkg::NUM_CNT-1:0][nts_pkg::API_DATA_W-1:0] o_lsb
);

  import nts_pkg::*;

  logic [NUM_CNT-1:0][API_DATA_W-1:0] lsb_reg;

  //------------------------------------------------------------
  // Snapshot registers
  //------------------------------------------------------------

  // The strobe comes from a read of the upper word, so the lower
  // word captured here pairs with the upper word just returned.
  // An event at the same edge lands in the counter, not here.
  always_ff @(posedge i_clk or posedge i_areset)
  begin : lsb_update
    if (i_areset)
    begin
      lsb_reg <= '0;
    end
    else
    begin
      for (int i = 0; i < NUM_CNT; i++)
      begin
        if (i_load[i])
        begin
          lsb_reg[i] <= i_count[i][API_DATA_W-1:0]; // Value before the edge
        end
      end
    end
  end

  assign o_lsb = lsb_reg;

endmodule

`default_nettype wire

// ==== nts_pkg.sv ====
// NTS engine statistics definitions
`default_nettype none

package nts_pkg;

  //------------------------------------------------------------
  // API address and data widths
  //------------------------------------------------------------

  localparam int API_ADDR_W   = 12;
  localparam int API_DATA_W   = 32;
  localparam int API_OFFSET_W = 8;
  localparam int API_BLOCK_W  = 4;

  // One address word, seen raw or as block and offset
  typedef union packed {
    logic [API_ADDR_W-1:0] raw;
    struct packed {
      logic [API_BLOCK_W-1:0]  block;
      logic [API_OFFSET_W-1:0] offset;
    } field;
  } api_addr_t;

  localparam logic [API_BLOCK_W-1:0] BLOCK_ENGINE = 4'd0;
  localparam logic [API_BLOCK_W-1:0] BLOCK_DEBUG  = 4'd3;

  //------------------------------------------------------------
  // Engine block
  //------------------------------------------------------------

  localparam logic [API_OFFSET_W-1:0] ADDR_NAME0   = 8'h00;
  localparam logic [API_OFFSET_W-1:0] ADDR_NAME1   = 8'h01;
  localparam logic [API_OFFSET_W-1:0] ADDR_VERSION = 8'h02;
  localparam logic [API_OFFSET_W-1:0] ADDR_CTRL    = 8'h08;

  localparam logic [API_DATA_W-1:0] CORE_NAME0   = 32'h4e_54_53_5f; // "NTS_"
  localparam logic [API_DATA_W-1:0] CORE_NAME1   = 32'h45_4e_47_4e; // "ENGN"
  localparam logic [API_DATA_W-1:0] CORE_VERSION = 32'h30_2e_30_32; // "0.02"
  localparam logic [API_DATA_W-1:0] CTRL_VALUE   = 32'h0000_0001;

  //------------------------------------------------------------
  // Debug block
  //------------------------------------------------------------

  localparam logic [API_OFFSET_W-1:0] ADDR_DEBUG_NAME      = 8'h08;
  localparam logic [API_OFFSET_W-1:0] ADDR_DEBUG_SYSTICK32 = 8'h09;

  localparam logic [API_DATA_W-1:0] DEBUG_NAME = 32'h44_42_55_47; // "DBUG"

  localparam int CNT_W   = 64;
  localparam int NUM_CNT = 6;

  // Counter index, also the bit of the event vector
  localparam int CNT_PROCESSED  = 0;
  localparam int CNT_BAD_COOKIE = 1;
  localparam int CNT_BAD_AUTH   = 2;
  localparam int CNT_BAD_KEYID  = 3;
  localparam int CNT_ERR_CRYPTO = 4;
  localparam int CNT_ERR_TXBUF  = 5;

  // Upper-word offset per counter; lower word sits one above
  localparam logic [API_OFFSET_W-1:0] CNT_ADDR [NUM_CNT] = '{
    CNT_PROCESSED:  8'h00,
    CNT_BAD_COOKIE: 8'h02,
    CNT_BAD_AUTH:   8'h04,
    CNT_BAD_KEYID:  8'h06,
    CNT_ERR_CRYPTO: 8'h20,
    CNT_ERR_TXBUF:  8'h22
  };

endpackage

`default_nettype wire

// ==== nts_stat_counters.sv ====
// Event counters and system tick
`timescale 1ns/10ps
`default_nettype none

module nts_stat_counters (
  input  wire                                            i_clk,
  input  wire                                            i_areset,
  input  wire  [nts_pkg::NUM_CNT-1:0]                    i_evt,     // One pulse per event
  output logic [nts_pkg::NUM_CNT-1:0][nts_pkg::CNT_W-1:0] o_count,
  output logic [nts_pkg::API_DATA_W-1:0]                 o_systick
);

  import nts_pkg::*;

  //------------------------------------------------------------
  // Registers
  //------------------------------------------------------------

  logic [NUM_CNT-1:0][CNT_W-1:0] count_reg;
  logic [API_DATA_W-1:0]         systick_reg;

  //------------------------------------------------------------
  // Event counters
  //------------------------------------------------------------

  // Plain wrap-around counters, 64 bits never overflow in practice
  always_ff @(posedge i_clk or posedge i_areset)
  begin : cnt_update
    if (i_areset)
    begin
      count_reg <= '0;
    end
    else
    begin
      for (int i = 0; i < NUM_CNT; i++)
      begin
        if (i_evt[i])
        begin
          count_reg[i] <= count_reg[i] + CNT_W'(1);
        end
      end
    end
  end

  //------------------------------------------------------------
  // Free running tick
  //------------------------------------------------------------

  // Starts at one so the first cycle out of reset reads as tick 1
  always_ff @(posedge i_clk or posedge i_areset)
  begin : tick_update
    if (i_areset)
    begin
      systick_reg <= API_DATA_W'(1);
    end
    else
    begin
      systick_reg <= systick_reg + API_DATA_W'(1);
    end
  end

  assign o_count   = count_reg;
  assign o_systick = systick_reg;

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the NTS engine statistics testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module tb_nts_engine_stats -f vlog.f

# The log search below decides the result
./obj_dir/Vtb_nts_engine_stats > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Regression failed" "$LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi
if ! grep -q "Regression passed" "$LOG"; then
  echo "Simulation ended without a result line"
  exit 1
fi

// ==== tb_checker.sv ====
// Read data reference model and checker
`timescale 1ns/10ps
`default_nettype none

module tb_checker (
  input  wire        i_clk,
  input  wire        i_areset,
  input  wire        i_api_cs,
  input  wire        i_api_we,
  input  wire [11:0] i_api_address,
  input  wire [5:0]  i_evt,
  input  wire [31:0] i_read_data,
  input  wire        i_exp_en,   // Table row carries a fixed value
  input  wire [31:0] i_exp,
  output int         o_errors
);

  // Counter upper-word offsets in the debug block
  localparam logic [7:0] UPPER_OFS [6] = '{8'h00, 8'h02, 8'h04, 8'h06, 8'h20, 8'h22};

  logic [63:0] model_cnt [6];
  logic [31:0] model_lsb [6];
  logic [31:0] model_tick;
  int          err_count = 0;

  assign o_errors = err_count;

  // Register map read against the model state
  function automatic logic [31:0] model_read(input logic [11:0] addr);
    logic [31:0] val;
    val = 32'h0;
    if (addr[11:8] == 4'h0)
    begin
      case (addr[7:0])
        8'h00:   val = "NTS_";
        8'h01:   val = "ENGN";
        8'h02:   val = "0.02";
        8'h08:   val = 32'h1;
        default: val = 32'h0;
      endcase
    end
    else if (addr[11:8] == 4'h3)
    begin
      if (addr[7:0] == 8'h08)
      begin
        val = "DBUG";
      end
      if (addr[7:0] == 8'h09)
      begin
        val = model_tick;
      end
      for (int i = 0; i < 6; i++)
      begin
        if (addr[7:0] == UPPER_OFS[i])
        begin
          val = model_cnt[i][63:32];
        end
        if (addr[7:0] == UPPER_OFS[i] + 8'd1)
        begin
          val = model_lsb[i];  // Lower word comes from the snapshot
        end
      end
    end
    return val;
  endfunction

  //------------------------------------------------------------
  // Compare at the falling edge, then step the model
  //------------------------------------------------------------

  always @(negedge i_clk)
  begin : compare
    logic        is_read;
    logic [31:0] want;
    is_read = i_api_cs && !i_api_we;
    if (i_areset)
    begin
      for (int i = 0; i < 6; i++)
      begin
        model_cnt[i] = 64'h0;
        model_lsb[i] = 32'h0;
      end
      model_tick = 32'h1;
    end
    else
    begin
      want = is_read ? model_read(i_api_address) : 32'h0;
      if (i_read_data !== want)
      begin
        $display("ERR o_api_read_data addr=%h model=%h got=%h",
                 i_api_address, want, i_read_data);
        err_count++;
      end
      if (i_exp_en && (i_read_data !== i_exp))
      begin
        $display("ERR o_api_read_data addr=%h table=%h got=%h",
                 i_api_address, i_exp, i_read_data);
        err_count++;
      end

      // State after the next rising edge
      for (int i = 0; i < 6; i++)
      begin
        if (is_read && (i_api_address == {4'h3, UPPER_OFS[i]}))
        begin
          model_lsb[i] = model_cnt[i][31:0];  // Count before this edge
        end
        if (i_evt[i])
        begin
          model_cnt[i] = model_cnt[i] + 64'd1;
        end
      end
      model_tick = model_tick + 32'd1;
    end
  end

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
// Testbench clock and reset
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 10
) (
  output logic o_clk,
  output logic o_areset
);

  initial
  begin : clock
    o_clk = 1'b0;
    forever
    begin
      #(PERIOD_NS / 2) o_clk = ~o_clk;
    end
  end

  // Reset drops on a rising edge, after the DUT flops have seen it high
  initial
  begin : reset_seq
    o_areset = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clk);
    o_areset <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== tb_nts_engine_stats.sv ====
// NTS engine statistics testbench
`timescale 1ns/10ps
`default_nettype none

module tb_nts_engine_stats;

  localparam logic [2:0] OP_IDLE  = 3'd0;
  localparam logic [2:0] OP_EVT   = 3'd1;
  localparam logic [2:0] OP_READ  = 3'd2;
  localparam logic [2:0] OP_WRITE = 3'd3;
  localparam logic [2:0] OP_RAND  = 3'd4;  // Random event mask each cycle

  localparam logic [7:0] UPPER_OFS [6] = '{8'h00, 8'h02, 8'h04, 8'h06, 8'h20, 8'h22};

  typedef struct packed {
    logic [2:0]  op;
    logic [11:0] addr;
    logic [5:0]  mask;
    logic [15:0] reps;
    logic        chk;   // Row has a fixed expected value
    logic [31:0] want;
  } row_t;

  logic        clk;
  logic        areset;
  logic        api_cs;
  logic        api_we;
  logic [11:0] api_address;
  logic [31:0] api_write_data;
  wire  [31:0] api_read_data;
  logic [5:0]  evt;
  logic        exp_en;
  logic [31:0] exp_value;
  int          errors;
  int          assert_fails;
  int          timeouts;
  int          seed;
  row_t        rows [$];

  //------------------------------------------------------------
  // Clock, DUT, checker and assertions
  //------------------------------------------------------------

  tb_clk_gen #(
    .PERIOD_NS    (4),
    .RESET_CYCLES (10)
  ) u_clk_gen (
    .o_clk    (clk),
    .o_areset (areset)
  );

  nts_engine_stats UUT (
    .i_clk            (clk),
    .i_areset         (areset),
    .i_api_cs         (api_cs),
    .i_api_we         (api_we),
    .i_api_address    (api_address),
    .i_api_write_data (api_write_data),
    .o_api_read_data  (api_read_data),
    .i_evt            (evt)
  );

  tb_checker u_checker (
    .i_clk         (clk),
    .i_areset      (areset),
    .i_api_cs      (api_cs),
    .i_api_we      (api_we),
    .i_api_address (api_address),
    .i_evt         (evt),
    .i_read_data   (api_read_data),
    .i_exp_en      (exp_en),
    .i_exp         (exp_value),
    .o_errors      (errors)
  );

  bind nts_engine_stats nts_engine_stats_sva u_sva (
    .i_clk           (i_clk),
    .i_areset        (i_areset),
    .i_api_cs        (i_api_cs),
    .i_api_we        (i_api_we),
    .i_api_read_data (o_api_read_data),
    .i_load          (lsb_load),
    .i_systick       (systick)
  );

  //------------------------------------------------------------
  // Stimulus table
  //------------------------------------------------------------

  function automatic logic [11:0] counter_addr(input int idx);
    return {4'h3, UPPER_OFS[idx]};
  endfunction

  task automatic add_row(input logic [2:0] op, input logic [11:0] addr,
                         input logic [5:0] mask, input int reps,
                         input logic chk, input logic [31:0] want);
    rows.push_back(row_t'({op, addr, mask, 16'(reps), chk, want}));
  endtask

  task automatic add_read(input logic [11:0] addr, input logic [31:0] want);
    add_row(OP_READ, addr, 6'h00, 1, 1'b1, want);
  endtask

  task automatic build_table();
    add_read(12'h000, "NTS_");
    add_read(12'h001, "ENGN");
    add_read(12'h002, "0.02");
    add_read(12'h008, 32'h1);
    add_read(12'h308, "DBUG");
    for (int i = 0; i < 6; i++)
    begin
      add_read(counter_addr(i), 32'h0);
      add_read(counter_addr(i) + 12'd1, 32'h0);
    end

    // Counter i sees i+3 lone pulses, then four on all six
    for (int i = 0; i < 6; i++)
    begin
      add_row(OP_EVT, 12'h000, 6'(1 << i), i + 3, 1'b0, 32'h0);
    end
    add_row(OP_EVT, 12'h000, 6'h3f, 4, 1'b0, 32'h0);
    for (int i = 0; i < 6; i++)
    begin
      add_read(counter_addr(i), 32'h0);
      add_read(counter_addr(i) + 12'd1, 32'(i + 7));
    end

    // Snapshot holds across later events
    add_read(counter_addr(0), 32'h0);
    add_row(OP_EVT, 12'h000, 6'h01, 2, 1'b0, 32'h0);
    add_read(counter_addr(0) + 12'd1, 32'd7);
    add_read(counter_addr(0), 32'h0);
    add_read(counter_addr(0) + 12'd1, 32'd9);
    add_row(OP_READ, counter_addr(0), 6'h01, 1, 1'b1, 32'h0);  // Event on the strobe edge
    add_read(counter_addr(0) + 12'd1, 32'd9);
    add_read(counter_addr(0), 32'h0);
    add_read(counter_addr(0) + 12'd1, 32'd10);

    // Writes change nothing, foreign blocks and holes read zero
    add_row(OP_EVT, 12'h000, 6'h01, 1, 1'b0, 32'h0);
    add_row(OP_WRITE, 12'h000, 6'h00, 1, 1'b1, 32'h0);
    add_row(OP_WRITE, 12'h300, 6'h00, 2, 1'b1, 32'h0);
    add_row(OP_WRITE, 12'h308, 6'h00, 1, 1'b1, 32'h0);
    add_row(OP_WRITE, 12'h323, 6'h00, 1, 1'b1, 32'h0);
    add_read(12'h100, 32'h0);
    add_read(12'h208, 32'h0);
    add_read(12'hf09, 32'h0);
    add_read(12'h003, 32'h0);
    add_read(12'h30a, 32'h0);
    add_read(12'h3ff, 32'h0);
    add_read(12'h000, "NTS_");
    add_read(12'h008, 32'h1);
    add_read(12'h301, 32'd10);
    add_read(12'h323, 32'd12);

    // Tick reads seven idle cycles apart, then back to back
    add_row(OP_READ, 12'h309, 6'h00, 1, 1'b0, 32'h0);
    add_row(OP_IDLE, 12'h000, 6'h00, 7, 1'b0, 32'h0);
    add_row(OP_READ, 12'h309, 6'h00, 3, 1'b0, 32'h0);

    add_row(OP_RAND, 12'h000, 6'h00, 400, 1'b0, 32'h0);
    for (int i = 0; i < 6; i++)
    begin
      add_row(OP_READ, counter_addr(i), 6'h00, 1, 1'b0, 32'h0);
      add_row(OP_READ, counter_addr(i) + 12'd1, 6'h00, 1, 1'b0, 32'h0);
    end
  endtask

  task automatic run_table();
    row_t row;
    for (int r = 0; r < rows.size(); r++)
    begin
      row = rows[r];
      for (int k = 0; k < int'(row.reps); k++)
      begin
        @(posedge clk);
        api_cs         <= (row.op == OP_READ) || (row.op == OP_WRITE);
        api_we         <= (row.op == OP_WRITE);
        api_address    <= row.addr;
        api_write_data <= $random(seed);
        exp_en         <= row.chk;
        exp_value      <= row.want;
        case (row.op)
          OP_EVT, OP_READ: evt <= row.mask;
          OP_RAND:         evt <= 6'($random(seed));
          default:         evt <= 6'h00;
        endcase
      end
    end
    @(posedge clk);
    api_cs <= 1'b0;
    evt    <= 6'h00;
    exp_en <= 1'b0;
  endtask

  //------------------------------------------------------------
  // Main sequence
  //------------------------------------------------------------

  initial
  begin : main
    int wait_cycles;
    api_cs         = 1'b0;
    api_we         = 1'b0;
    api_address    = 12'h000;
    api_write_data = 32'h0;
    evt            = 6'h00;
    exp_en         = 1'b0;
    exp_value      = 32'h0;
    seed           = 32'h9d71c81c;
    timeouts       = 0;
    assert_fails   = 0;
    wait_cycles    = 0;
    build_table();

    while ((areset !== 1'b0) && (wait_cycles < 40))
    begin
      @(posedge clk);
      wait_cycles++;
    end
    if (areset !== 1'b0)
    begin
      $display("Timeout: reset was not released within 40 cycles");
      timeouts++;
    end
    else
    begin
      run_table();
    end
    repeat (2) @(posedge clk);

    assert_fails = UUT.u_sva.fail_count;
    $display("Closing: %0d read errors, %0d assertion failures, %0d timeouts",
             errors, assert_fails, timeouts);
    if ((errors == 0) && (assert_fails == 0) && (timeouts == 0))
    begin
      $display("Regression passed");
    end
    else
    begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
nts_pkg.sv
nts_stat_counters.sv
nts_lsb_snapshot.sv
nts_debug_regs.sv
nts_api_decode.sv
nts_engine_stats.sv
tb_clk_gen.sv
tb_checker.sv
nts_engine_stats_sva.sv
tb_nts_engine_stats.sv
